/* design/amo_pipe_pkg.sv */
package amo_pipe_pkg;

    // Default widths.
    localparam int TAG_W       = 8;
    localparam int DEF_ADDR_W  = 10;
    localparam int WORD_ADDR_W = 16;   // Word index carried between stages.

    typedef logic [31:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;

    typedef enum logic [1:0] {
        MEM_OP_LOAD  = 2'd0,
        MEM_OP_STORE = 2'd1,
        MEM_OP_AMO   = 2'd2
    } mem_op_e;

    // Follows the funct5 order loosely, packed into 4 bits.
    typedef enum logic [3:0] {
        AMO_OP_SWAP = 4'd0,
        AMO_OP_ADD  = 4'd1,
        AMO_OP_AND  = 4'd2,
        AMO_OP_OR   = 4'd3,
        AMO_OP_XOR  = 4'd4,
        AMO_OP_MIN  = 4'd5,
        AMO_OP_MAX  = 4'd6,
        AMO_OP_MINU = 4'd7,
        AMO_OP_MAXU = 4'd8
    } amo_op_e;

    // Stage 1 to stage 2 payload, 63 bits.
    typedef struct packed {
        mem_op_e    mem_op;
        amo_op_e    amo_op;
        word_addr_t word_addr;
        word_t      wdata;       // rs2 value.
        tag_t       tag;
        logic       fault;       // Misaligned or out of range.
    } m1_to_m2_s;

endpackage : amo_pipe_pkg

/* design/amo_pipe_top.sv */
`timescale 1ns/1ps

module amo_pipe_top #(
    parameter int ADDR_W = amo_pipe_pkg::DEF_ADDR_W,
    parameter int TAG_W  = amo_pipe_pkg::TAG_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,

    input  logic                  in_valid,
    input  amo_pipe_pkg::mem_op_e in_op,
    input  amo_pipe_pkg::amo_op_e in_amo,
    input  logic [31:0]           in_addr,
    input  amo_pipe_pkg::word_t   in_wdata,
    input  logic [TAG_W-1:0]      in_tag,
    output logic                  in_ready,

    output logic                  res_valid,
    output amo_pipe_pkg::word_t   res_data,
    output logic [TAG_W-1:0]      res_tag,
    output logic                  res_fault,
    input  logic                  res_ready
);

    // Stage boundary.
    logic                    m1_valid;
    amo_pipe_pkg::m1_to_m2_s m1_to_m2;
    logic                    m2_stall;

    dmem_if #(.ADDR_W(ADDR_W)) dmem ();

    mem_stage1 #(
        .ADDR_W (ADDR_W),
        .TAG_W  (TAG_W)
    ) u_stage1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .m2_stall (m2_stall),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_amo   (in_amo),
        .in_addr  (in_addr),
        .in_wdata (in_wdata),
        .in_tag   (in_tag),
        .in_ready (in_ready),
        .m1_valid (m1_valid),
        .m1_to_m2 (m1_to_m2),
        .dmem     (dmem.stage1)
    );

    mem_stage2 #(
        .ADDR_W (ADDR_W),
        .TAG_W  (TAG_W)
    ) u_stage2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .res_ready (res_ready),
        .m1_valid  (m1_valid),
        .m1_to_m2  (m1_to_m2),
        .m2_stall  (m2_stall),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_tag   (res_tag),
        .res_fault (res_fault),
        .dmem      (dmem.stage2)
    );

    data_ram #(
        .ADDR_W (ADDR_W)
    ) u_ram (
        .clk  (clk),
        .dmem (dmem.ram)
    );

endmodule : amo_pipe_top

/* design/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
    parameter int ADDR_W = amo_pipe_pkg::DEF_ADDR_W
) (
    input  logic clk,
    dmem_if.ram  dmem
);

    localparam int DEPTH = 2 ** ADDR_W;

    amo_pipe_pkg::word_t mem [DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (dmem.wr_en) begin
            mem[dmem.wr_addr] <= dmem.wr_data;
        end
    end

    // Read-first; output register holds while rd_en is low.
    always_ff @(posedge clk) begin
        if (dmem.rd_en) begin
            dmem.rd_data <= mem[dmem.rd_addr];
        end
    end

endmodule : data_ram

/* design/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if #(
    parameter int ADDR_W = amo_pipe_pkg::DEF_ADDR_W
);

    // Read port, issued by stage 1, data returned to stage 2.
    logic                rd_en;
    logic [ADDR_W-1:0]   rd_addr;
    amo_pipe_pkg::word_t rd_data;

    // Write port, committed by stage 2.
    logic                wr_en;
    logic [ADDR_W-1:0]   wr_addr;
    amo_pipe_pkg::word_t wr_data;

    modport stage1 (
        output rd_en,
        output rd_addr
    );

    modport stage2 (
        input  rd_data,
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport ram (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        input  wr_en,
        input  wr_addr,
        input  wr_data
    );

endinterface : dmem_if

/* design/mem_stage1.sv */
`timescale 1ns/1ps

module mem_stage1 #(
    parameter int ADDR_W = amo_pipe_pkg::DEF_ADDR_W,
    parameter int TAG_W  = amo_pipe_pkg::TAG_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      m2_stall,

    input  logic                      in_valid,
    input  amo_pipe_pkg::mem_op_e     in_op,
    input  amo_pipe_pkg::amo_op_e     in_amo,
    input  logic [31:0]               in_addr,    // Byte address.
    input  amo_pipe_pkg::word_t       in_wdata,
    input  logic [TAG_W-1:0]          in_tag,
    output logic                      in_ready,

    output logic                      m1_valid,
    output amo_pipe_pkg::m1_to_m2_s   m1_to_m2,

    dmem_if.stage1                    dmem
);

    logic in_misaligned;
    logic in_out_of_range;
    logic need_read;

    // Word aligned and inside the RAM.
    assign in_misaligned   = (in_addr[1:0] != 2'b00);
    assign in_out_of_range = (in_addr[31:ADDR_W+2] != '0);

    // The whole pipe advances together.
    assign in_ready = !m2_stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid <= 1'b0;
        end else if (flush) begin
            m1_valid <= 1'b0;   // Squash.
        end else if (!m2_stall) begin
            m1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!m2_stall) begin
            m1_to_m2 <= '{
                mem_op:    in_op,
                amo_op:    in_amo,
                word_addr: in_addr[amo_pipe_pkg::WORD_ADDR_W+1:2],
                wdata:     in_wdata,
                tag:       amo_pipe_pkg::tag_t'(in_tag),
                fault:     in_misaligned || in_out_of_range
            };
        end
    end

    // Stores and faults skip the read.
    assign need_read = !m1_to_m2.fault && (m1_to_m2.mem_op != amo_pipe_pkg::MEM_OP_STORE);

    // Read lands in the RAM output register on the edge that loads stage 2.
    assign dmem.rd_en   = m1_valid && !m2_stall && need_read;
    assign dmem.rd_addr = m1_to_m2.word_addr[ADDR_W-1:0];

endmodule : mem_stage1

/* design/mem_stage2.sv */
`timescale 1ns/1ps

module mem_stage2 #(
    parameter int ADDR_W = amo_pipe_pkg::DEF_ADDR_W,
    parameter int TAG_W  = amo_pipe_pkg::TAG_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      res_ready,

    input  logic                      m1_valid,
    input  amo_pipe_pkg::m1_to_m2_s   m1_to_m2,
    output logic                      m2_stall,

    output logic                      res_valid,
    output amo_pipe_pkg::word_t       res_data,
    output logic [TAG_W-1:0]          res_tag,
    output logic                      res_fault,

    dmem_if.stage2                    dmem
);

    logic                    m2_valid;
    amo_pipe_pkg::m1_to_m2_s m2_q;
    logic                    res_accept;
    logic                    does_write;

    // Last committed write.
    logic                    fwd_valid;
    logic [ADDR_W-1:0]       fwd_addr;
    amo_pipe_pkg::word_t     fwd_data;

    amo_pipe_pkg::word_t     old_word;
    amo_pipe_pkg::word_t     new_word;
    amo_pipe_pkg::word_t     amo_result;

    assign m2_stall = m2_valid && !res_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m2_valid <= 1'b0;
        end else if (flush) begin
            m2_valid <= 1'b0;
        end else if (!m2_stall) begin
            m2_valid <= m1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!m2_stall) begin
            m2_q <= m1_to_m2;
        end
    end

    assign res_valid  = m2_valid && !flush;
    assign res_accept = res_valid && res_ready;

    // The RAM is read-first, so a write on the read edge is missed.
    assign old_word = (fwd_valid && (fwd_addr == m2_q.word_addr[ADDR_W-1:0]))
                    ? fwd_data : dmem.rd_data;

    always_comb begin
        case (m2_q.amo_op)
            amo_pipe_pkg::AMO_OP_SWAP: amo_result = m2_q.wdata;
            amo_pipe_pkg::AMO_OP_ADD:  amo_result = old_word + m2_q.wdata;
            amo_pipe_pkg::AMO_OP_AND:  amo_result = old_word & m2_q.wdata;
            amo_pipe_pkg::AMO_OP_OR:   amo_result = old_word | m2_q.wdata;
            amo_pipe_pkg::AMO_OP_XOR:  amo_result = old_word ^ m2_q.wdata;
            amo_pipe_pkg::AMO_OP_MIN:
                amo_result = ($signed(old_word) < $signed(m2_q.wdata)) ? old_word : m2_q.wdata;
            amo_pipe_pkg::AMO_OP_MAX:
                amo_result = ($signed(old_word) > $signed(m2_q.wdata)) ? old_word : m2_q.wdata;
            amo_pipe_pkg::AMO_OP_MINU:
                amo_result = (old_word < m2_q.wdata) ? old_word : m2_q.wdata;
            amo_pipe_pkg::AMO_OP_MAXU:
                amo_result = (old_word > m2_q.wdata) ? old_word : m2_q.wdata;
            default:                   amo_result = m2_q.wdata;   // Unused codes act as swap.
        endcase
    end

    assign new_word = (m2_q.mem_op == amo_pipe_pkg::MEM_OP_AMO) ? amo_result : m2_q.wdata;

    // Only stores and AMOs that did not fault.
    assign does_write = !m2_q.fault && (m2_q.mem_op != amo_pipe_pkg::MEM_OP_LOAD);

    assign dmem.wr_en   = res_accept && does_write;
    assign dmem.wr_addr = m2_q.word_addr[ADDR_W-1:0];
    assign dmem.wr_data = new_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fwd_valid <= 1'b0;
        end else if (dmem.wr_en) begin
            fwd_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem.wr_en) begin
            fwd_addr <= dmem.wr_addr;
            fwd_data <= dmem.wr_data;
        end
    end

    // Old word back to the caller. Stores and faults return zero.
    assign res_data  = (m2_q.fault || (m2_q.mem_op == amo_pipe_pkg::MEM_OP_STORE))
                     ? '0 : old_word;
    assign res_tag   = TAG_W'(m2_q.tag);
    assign res_fault = m2_q.fault;

endmodule : mem_stage2

/* dv/amo_pipe_asserts.sv */
`timescale 1ns/1ps

module amo_pipe_asserts #(
    parameter int ADDR_W = amo_pipe_pkg::DEF_ADDR_W,
    parameter int TAG_W  = amo_pipe_pkg::TAG_W
) (
    input logic                  clk, rst_n, flush, in_valid, in_ready, res_valid, res_ready,
    input amo_pipe_pkg::mem_op_e in_op,
    input amo_pipe_pkg::amo_op_e in_amo,
    input logic [31:0]           in_addr,
    input amo_pipe_pkg::word_t   in_wdata, res_data,
    input logic [TAG_W-1:0]      in_tag, res_tag,
    input logic                  res_fault
);

    typedef struct packed {
        amo_pipe_pkg::mem_op_e op;
        amo_pipe_pkg::amo_op_e amo;
        logic [31:0]           addr;
        amo_pipe_pkg::word_t   wdata;
        logic [TAG_W-1:0]      tag;
    } op_rec_t;

    op_rec_t             pend [4];   // Accepted and not yet returned, oldest first.
    int                  pend_cnt = 0;
    int                  fail_count = 0;
    amo_pipe_pkg::word_t shadow [2**ADDR_W];
    logic                shadow_known [2**ADDR_W] = '{default: 1'b0};
    op_rec_t             head;
    logic [ADDR_W-1:0]   head_idx;
    logic                head_fault, take, give, exp_known;
    amo_pipe_pkg::word_t exp_data;

    // New memory word for an AMO, from the old word m and the operand v.
    function automatic amo_pipe_pkg::word_t amo_apply(input amo_pipe_pkg::amo_op_e op,
                                                      input amo_pipe_pkg::word_t m,
                                                      input amo_pipe_pkg::word_t v);
        case (op)
            amo_pipe_pkg::AMO_OP_ADD:  return m + v;
            amo_pipe_pkg::AMO_OP_AND:  return m & v;
            amo_pipe_pkg::AMO_OP_OR:   return m | v;
            amo_pipe_pkg::AMO_OP_XOR:  return m ^ v;
            amo_pipe_pkg::AMO_OP_MIN:  return ($signed(v) < $signed(m)) ? v : m;
            amo_pipe_pkg::AMO_OP_MAX:  return ($signed(v) > $signed(m)) ? v : m;
            amo_pipe_pkg::AMO_OP_MINU: return (v < m) ? v : m;
            amo_pipe_pkg::AMO_OP_MAXU: return (v > m) ? v : m;
            default:                   return v;   // Swap.
        endcase
    endfunction

    assign head       = pend[0];
    assign head_idx   = head.addr[ADDR_W+1:2];
    assign head_fault = (head.addr[1:0] != 2'b00) || (head.addr[31:ADDR_W+2] != '0);
    assign take       = in_valid && in_ready;
    assign give       = res_valid && res_ready && (pend_cnt > 0);
    assign exp_known  = head_fault || (head.op == amo_pipe_pkg::MEM_OP_STORE) || shadow_known[head_idx];
    assign exp_data   = (head_fault || (head.op == amo_pipe_pkg::MEM_OP_STORE)) ? '0 : shadow[head_idx];

    always @(posedge clk) begin
        if (!rst_n || flush) begin
            pend_cnt <= 0;   // Flush squashes everything in flight.
        end else begin
            if (give) begin
                pend[0] <= pend[1];
                pend[1] <= pend[2];
                pend[2] <= pend[3];
                if (!head_fault && (head.op != amo_pipe_pkg::MEM_OP_LOAD)) begin
                    shadow[head_idx] <= (head.op == amo_pipe_pkg::MEM_OP_AMO)
                                      ? amo_apply(head.amo, shadow[head_idx], head.wdata)
                                      : head.wdata;
                    shadow_known[head_idx] <= shadow_known[head_idx]
                                           || (head.op == amo_pipe_pkg::MEM_OP_STORE);
                end
            end
            if (take && ((pend_cnt - give) < 4)) begin
                pend[pend_cnt - give] <= '{in_op, in_amo, in_addr, in_wdata, in_tag};
            end
            pend_cnt <= pend_cnt + take - give;
        end
    end

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !res_valid && in_ready)
        else begin
            fail_count++;
            $error("[FAIL] after reset res_valid=%h in_ready=%h",
                   $sampled(res_valid), $sampled(in_ready));
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> flush || (res_valid && $stable(res_data)
                                    && $stable(res_tag) && $stable(res_fault)))
        else begin
            fail_count++;
            $error("Held result changed or dropped before res_ready was given");
        end

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        give && exp_known |-> res_data == exp_data)
        else begin
            fail_count++;
            $error("[FAIL] res_data got %h expected %h", $sampled(res_data), $sampled(exp_data));
        end

    a_tag: assert property (@(posedge clk) disable iff (!rst_n) give |-> res_tag == head.tag)
        else begin
            fail_count++;
            $error("[FAIL] res_tag got %h expected %h", $sampled(res_tag), $sampled(head.tag));
        end

    a_fault: assert property (@(posedge clk) disable iff (!rst_n) give |-> res_fault == head_fault)
        else begin
            fail_count++;
            $error("[FAIL] res_fault got %h expected %h",
                   $sampled(res_fault), $sampled(head_fault));
        end

    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n) flush |-> !res_valid)
        else begin
            fail_count++;
            $error("[FAIL] res_valid=%h while flush is high", $sampled(res_valid));
        end

    a_no_ghost: assert property (@(posedge clk) disable iff (!rst_n) res_valid |-> pend_cnt > 0)
        else begin
            fail_count++;
            $error("Result returned with no operation in flight");
        end

endmodule : amo_pipe_asserts

bind amo_pipe_top amo_pipe_asserts #(.ADDR_W(ADDR_W), .TAG_W(TAG_W)) u_asserts (.*);

/* dv/amo_pipe_tb.sv */
`timescale 1ns/1ps

module amo_pipe_tb;

    localparam int N_OPS   = 400;
    localparam int TIMEOUT = 200;
    localparam int POOL [8] = '{0, 1, 2, 3, 5, 100, 511, 1023};   // Word indices.

    logic                  clk, rst_n, flush, in_valid, in_ready, res_valid, res_ready, res_fault;
    amo_pipe_pkg::mem_op_e in_op;
    amo_pipe_pkg::amo_op_e in_amo;
    logic [31:0]           in_addr;
    amo_pipe_pkg::word_t   in_wdata, res_data;
    logic [7:0]            in_tag, res_tag;
    int                    timeouts = 0;

    amo_pipe_top uut (.*);

    always #20 clk = ~clk;

    // First eight calls store to each pool word, later ones are random.
    task automatic drive_op(input int init_idx);
        int          idx;
        logic [31:0] addr;
        idx  = (init_idx >= 0) ? init_idx : int'($urandom_range(0, 7));
        addr = 32'(POOL[idx]) << 2;
        if (init_idx < 0 && $urandom_range(0, 15) == 0)
            addr = addr + $urandom_range(1, 3);   // Misaligned.
        if (init_idx < 0 && $urandom_range(0, 31) == 0)
            addr = addr | 32'h0004_0000;         // Beyond the RAM.
        in_valid <= 1'b1;
        in_op    <= (init_idx >= 0) ? amo_pipe_pkg::MEM_OP_STORE
                                    : amo_pipe_pkg::mem_op_e'($urandom_range(0, 2));
        in_amo   <= amo_pipe_pkg::amo_op_e'($urandom_range(0, 8));
        in_addr  <= addr;
        in_wdata <= $urandom;
        in_tag   <= in_tag + 8'd1;
    endtask

    initial begin
        int          sent;
        int          stuck;
        int          idle;
        bit          accepted;
        void'($urandom(32'h3a9f_5e95));
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        in_op = amo_pipe_pkg::MEM_OP_LOAD;
        in_amo = amo_pipe_pkg::AMO_OP_SWAP;
        in_addr = '0;
        in_wdata = '0;
        in_tag = '0;
        res_ready = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        sent = 0;
        stuck = 0;
        accepted = 1'b0;
        while (sent < N_OPS && stuck < TIMEOUT) begin
            @(posedge clk);
            res_ready <= (sent < 12) || ($urandom_range(0, 3) != 0);
            flush     <= (sent >= 12) && ($urandom_range(0, 49) == 0);   // Rare squash.
            if (accepted || !in_valid) begin
                stuck = 0;
                if (sent >= 8 && $urandom_range(0, 3) == 0)
                    in_valid <= 1'b0;
                else
                    drive_op((sent < 8) ? sent : -1);
            end else begin
                stuck++;
            end
            @(negedge clk);
            accepted = in_valid && in_ready;   // Taken on the next rising edge.
            if (accepted)
                sent++;
        end
        if (stuck >= TIMEOUT) begin
            timeouts++;
            $display("ERROR: operation not accepted within %0d cycles", TIMEOUT);
        end

        // Drain until every accepted operation has returned.
        @(posedge clk);
        in_valid  <= 1'b0;
        res_ready <= 1'b1;
        flush     <= 1'b0;
        idle = 0;
        stuck = 0;
        while ((idle < 4 || uut.u_asserts.pend_cnt != 0) && stuck < TIMEOUT) begin
            @(negedge clk);
            stuck++;
            idle = res_valid ? 0 : idle + 1;
        end
        if (idle < 4 || uut.u_asserts.pend_cnt != 0) begin
            timeouts++;
            $display("ERROR: pipe did not drain within %0d cycles, %0d operations never returned",
                     TIMEOUT, uut.u_asserts.pend_cnt);
        end

        $display("Done: %0d operations, %0d timeouts, %0d assertion failures",
                 sent, timeouts, uut.u_asserts.fail_count);
        if (timeouts == 0 && uut.u_asserts.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : amo_pipe_tb

/* filelist.f */
design/amo_pipe_pkg.sv
design/dmem_if.sv
design/data_ram.sv
design/mem_stage1.sv
design/mem_stage2.sv
design/amo_pipe_top.sv
dv/amo_pipe_asserts.sv
dv/amo_pipe_tb.sv
